// File: dcache_pkg.sv
// ########################################
// Shared geometry and address types for the
// direct-mapped write-through data cache.
// Imported by both stages and both interfaces
// ########################################

package dcache_pkg;

	localparam int ADDR_W         = 32;
	localparam int TAG_W          = 22;
	localparam int IDX_W          = 4;
	localparam int WORD_IDX_W     = 4;
	localparam int BYTE_OFF_W     = 2;  // 32-bit words on the bus
	localparam int NUM_LINES      = 16;
	localparam int WORDS_PER_LINE = 16;

	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [IDX_W-1:0]      line_idx_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// One address word, seen whole or as its cache fields
	// [31:10] tag, [9:6] line index, [5:2] word in line, [1:0] byte
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			tag_t                  tag;
			line_idx_t             idx;
			word_idx_t             word;
			logic [BYTE_OFF_W-1:0] byte_off;
		} f;
	} dcache_addr_u;

endpackage

// File: dcache_fill_if.sv
// ########################################
// Miss requests and line-fill beats between
// the lookup stage and the miss stage
// ########################################

`timescale 1ns/1ns

interface dcache_fill_if;
	import dcache_pkg::*;

	logic        rd_miss;            // Read requested and not resident
	logic        hit;
	logic        line_addr_changed;  // Line differs from last cycle
	logic        fill_we;            // Write fill_data into the indexed line
	word_idx_t   fill_pos;
	logic [31:0] fill_data;
	logic        fill_done;          // Last beat, store tag and valid

	modport lookup (
		output rd_miss, hit, line_addr_changed,
		input  fill_we, fill_pos, fill_data, fill_done
	);

	modport miss (
		input  rd_miss, hit, line_addr_changed,
		output fill_we, fill_pos, fill_data, fill_done
	);

endinterface

// File: dcache_bus_if.sv
// ########################################
// Memory bus bundle between the miss stage
// and the top-level bus ports
// ########################################

`timescale 1ns/1ns

interface dcache_bus_if;
	import dcache_pkg::*;

	logic         bus_req;    // Read miss or write pending
	dcache_addr_u bus_addr;
	logic [31:0]  bus_wdata;
	logic         bus_rd;     // Only while bus_ack is high
	logic         bus_wr;
	logic         bus_ack;    // Grant level from the bus
	logic [31:0]  bus_rdata;
	logic         bus_ready;  // Beat accepted this cycle

	modport master (
		output bus_req, bus_addr, bus_wdata, bus_rd, bus_wr,
		input  bus_ack, bus_rdata, bus_ready
	);

	modport top (
		input  bus_req, bus_addr, bus_wdata, bus_rd, bus_wr,
		output bus_ack, bus_rdata, bus_ready
	);

endinterface

// File: dcache_lookup.sv
// ########################################
// Lookup stage: valid, tag and data arrays.
// Reads hit combinationally; fill beats and
// write hits update the arrays on the edge
// ########################################

`timescale 1ns/1ns

module dcache_lookup (
	input  logic                     clk,
	input  logic                     arst_n,
	input  dcache_pkg::dcache_addr_u addr,
	input  logic                     rd_req,
	input  logic                     wr_req,
	input  logic [31:0]              wr_data,
	input  logic                     wr_done,
	output logic [31:0]              rd_data,
	dcache_fill_if.lookup            fill
);
	import dcache_pkg::*;

	logic [NUM_LINES-1:0] valid;
	tag_t                 tags [NUM_LINES];
	logic [31:0]          data [NUM_LINES][WORDS_PER_LINE];

	line_idx_t               idx;
	tag_t                    tag;
	word_idx_t               word;
	logic                    hit;
	logic [TAG_W+IDX_W-1:0]  cur_line;
	logic [TAG_W+IDX_W-1:0]  prev_line;

	assign idx      = addr.f.idx;
	assign tag      = addr.f.tag;
	assign word     = addr.f.word;
	assign cur_line = {tag, idx};

	assign hit = valid[idx] && (tags[idx] == tag);

	assign fill.hit               = hit;
	assign fill.rd_miss           = rd_req && !hit;
	assign fill.line_addr_changed = (cur_line != prev_line);

	// No wait state on a hit
	assign rd_data = data[idx][word];

	// Valid bits and the last seen line address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid     <= '0;          // Every line invalid
			prev_line <= '1;
		end else begin
			prev_line <= cur_line;
			if (fill.fill_we && fill.fill_done)
				valid[idx] <= 1'b1;   // Whole line now present
		end
	end

	// Tag and line storage
	always_ff @(posedge clk) begin
		if (fill.fill_we) begin
			data[idx][fill.fill_pos] <= fill.fill_data;
			if (fill.fill_done)
				tags[idx] <= tag;
		end else if (wr_done && hit) begin
			data[idx][word] <= wr_data;  // Write-through keeps the copy in step
		end
	end

	// A fill only runs on a read miss, so it can never meet a write hit
	assert property (@(posedge clk) disable iff (!arst_n)
		!(fill.fill_we && wr_req && hit))
		else $error("fill beat during a write hit");

	// A line turns valid only on the edge that took its last fill beat
	assert property (@(posedge clk) disable iff (!arst_n)
		((valid & ~$past(valid)) != '0) |-> $past(fill.fill_we && (fill.fill_pos == '1)))
		else $error("valid bit set without a fill beat");

endmodule

// File: dcache_miss.sv
// ########################################
// Miss stage: line fill sequencer and
// write-through issue on the memory bus.
// Produces the core wait and write done
// ########################################

`timescale 1ns/1ns

module dcache_miss (
	input  logic                     clk,
	input  logic                     arst_n,
	input  dcache_pkg::dcache_addr_u addr,
	input  logic                     rd_req,
	input  logic                     wr_req,
	input  logic [31:0]              wr_data,
	output logic                     rw_wait,
	output logic                     wr_done,
	dcache_fill_if.miss              fill,
	dcache_bus_if.master             bus
);
	import dcache_pkg::*;

	word_idx_t    fill_pos;
	dcache_addr_u fill_addr;
	logic         beat_done;
	logic         abandon;
	logic         rd_go;
	logic         wr_go;

	assign beat_done = bus.bus_ack && bus.bus_ready;

	// Request left the line or hit while a fill was under way
	assign abandon = rd_req && (fill_pos != '0) && (fill.line_addr_changed || fill.hit);

	assign rd_go = fill.rd_miss && !abandon;   // Reads win over writes
	assign wr_go = wr_req && !fill.rd_miss;

	// Line base plus the word being filled
	always_comb begin
		fill_addr          = addr;
		fill_addr.f.word   = fill_pos;
		fill_addr.f.byte_off = '0;
	end

	assign bus.bus_req = fill.rd_miss || wr_req;
	assign bus.bus_rd  = rd_go && bus.bus_ack;
	assign bus.bus_wr  = wr_go && bus.bus_ack;

	always_comb begin
		bus.bus_addr  = '0;
		bus.bus_wdata = '0;
		if (bus.bus_rd) begin
			bus.bus_addr = fill_addr;
		end else if (bus.bus_wr) begin
			bus.bus_addr  = addr;
			bus.bus_wdata = wr_data;
		end
	end

	assign fill.fill_we   = rd_go && beat_done;
	assign fill.fill_pos  = fill_pos;
	assign fill.fill_data = bus.bus_rdata;
	assign fill.fill_done = fill.fill_we && (fill_pos == '1);

	assign wr_done = wr_go && beat_done;

	// Held until the line is resident or the write beat is taken
	assign rw_wait = fill.rd_miss || (wr_req && !wr_done);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			fill_pos <= '0;
		else if (abandon)
			fill_pos <= '0;                 // Start the new line from word 0
		else if (fill.fill_we)
			fill_pos <= fill_pos + 1'b1;    // Wraps to 0 after the last beat
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		!(bus.bus_rd && bus.bus_wr))
		else $error("bus read and write strobes together");

	// Forward steps of the counter need a taken beat on the edge before
	assert property (@(posedge clk) disable iff (!arst_n)
		($changed(fill_pos) && (fill_pos != '0)) |-> $past(bus.bus_ready && bus.bus_ack))
		else $error("fill position moved without bus_ready");

endmodule

// File: dcache_top.sv
// ########################################
// Data cache top level: core load/store
// port and memory bus as plain ports
// ########################################

`timescale 1ns/1ns

module dcache_top (
	input  logic        clk,
	input  logic        arst_n,

	input  logic [31:0] addr,       // Core side
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic        rw_wait,
	output logic [31:0] rd_data,

	output logic        bus_req,    // Memory side
	output logic [31:0] bus_addr,
	output logic [31:0] bus_wdata,
	output logic        bus_rd,
	output logic        bus_wr,
	input  logic        bus_ack,
	input  logic [31:0] bus_rdata,
	input  logic        bus_ready
);
	import dcache_pkg::*;

	dcache_addr_u addr_u;
	logic         wr_done;

	dcache_fill_if fill ();
	dcache_bus_if  bus ();

	assign addr_u.raw = addr;

	assign bus_req   = bus.bus_req;
	assign bus_addr  = bus.bus_addr.raw;
	assign bus_wdata = bus.bus_wdata;
	assign bus_rd    = bus.bus_rd;
	assign bus_wr    = bus.bus_wr;

	assign bus.bus_ack   = bus_ack;
	assign bus.bus_rdata = bus_rdata;
	assign bus.bus_ready = bus_ready;

	dcache_lookup u_lookup (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (addr_u),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.wr_data (wr_data),
		.wr_done (wr_done),
		.rd_data (rd_data),
		.fill    (fill.lookup)
	);

	dcache_miss u_miss (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (addr_u),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.wr_data (wr_data),
		.rw_wait (rw_wait),
		.wr_done (wr_done),
		.fill    (fill.miss),
		.bus     (bus.master)
	);

endmodule

// File: tb_dcache.sv
// ########################################
// Testbench for the data cache top level.
// Models memory with random bus stalls and
// checks the core and bus rules by assertions
// ########################################

`timescale 1ns/1ns

module tb_dcache;

	localparam int TIMEOUT = 200;  // Cycles per wait loop

	logic        clk;
	logic        arst_n;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] wr_data;
	logic        rw_wait;
	logic [31:0] rd_data;
	logic        bus_req;
	logic [31:0] bus_addr;
	logic [31:0] bus_wdata;
	logic        bus_rd;
	logic        bus_wr;
	logic        bus_ack;
	logic [31:0] bus_rdata;
	logic        bus_ready;

	int errors = 0;
	int timeouts = 0;
	int rd_beats = 0;        // Completed bus read beats
	int wr_beats = 0;        // Completed bus write beats
	int beats_at_start = 0;

	logic [31:0] mem [logic [31:0]];  // Sparse memory of written words
	logic [21:0] sb_tag [16];         // Lines expected to be resident
	logic [15:0] sb_valid = '0;
	logic [3:0]  model_pos = '0;      // Expected fill position
	logic [25:0] prev_line = '1;

	logic        snap_rd_beat = 1'b0;
	logic        snap_wr_beat = 1'b0;
	logic [31:0] snap_wr_addr = '0;
	logic [31:0] snap_wr_data = '0;
	logic [25:0] snap_line = '0;
	logic        snap_abandon = 1'b0;

	logic        exp_hit = 1'b0;
	logic        exp_abandon = 1'b0;
	logic [31:0] exp_rd_data = '0;
	logic [31:0] exp_fill_addr = '0;

	dcache_top u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.wr_data   (wr_data),
		.rw_wait   (rw_wait),
		.rd_data   (rd_data),
		.bus_req   (bus_req),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		logic [31:0] key;
		key = {a[31:2], 2'b00};
		if (mem.exists(key))
			return mem[key];
		return key ^ 32'ha5a5a5a5;  // Unwritten words follow their address
	endfunction

	function automatic bit resident(input logic [31:0] a);
		return sb_valid[a[9:6]] && (sb_tag[a[9:6]] == a[31:10]);
	endfunction

	// Beats seen at the falling edge, where everything is settled
	always @(negedge clk) begin
		snap_rd_beat = bus_rd && bus_ack && bus_ready;
		snap_wr_beat = bus_wr && bus_ack && bus_ready;
		snap_wr_addr = bus_addr;
		snap_wr_data = bus_wdata;
		snap_line    = addr[31:6];
		snap_abandon = exp_abandon;
	end

	// Memory model, scoreboard and expected values
	always @(posedge clk) begin
		if (!arst_n) begin
			sb_valid  = '0;
			model_pos = '0;
			prev_line = '1;
		end else begin
			if (snap_wr_beat) begin
				mem[{snap_wr_addr[31:2], 2'b00}] = snap_wr_data;
				wr_beats++;
			end
			if (snap_abandon) begin
				model_pos = '0;                  // Fill restarts on the new line
			end else if (snap_rd_beat) begin
				rd_beats++;
				if (model_pos == 4'hf) begin
					sb_valid[snap_line[3:0]] = 1'b1;
					sb_tag[snap_line[3:0]]   = snap_line[25:4];
				end
				model_pos = model_pos + 4'd1;
			end
			prev_line = snap_line;
		end
		#1;
		bus_ack   = ($urandom % 4) != 0;     // Random stalls
		bus_ready = ($urandom % 4) != 0;
		#1;
		bus_rdata     = bus_rd ? mem_word(bus_addr) : 32'h0;
		exp_hit       = resident(addr);
		exp_rd_data   = mem_word(addr);
		exp_fill_addr = {addr[31:6], model_pos, 2'b00};
		exp_abandon   = rd_req && (model_pos != 4'h0) && ((addr[31:6] != prev_line) || exp_hit);
	end

	assert property (@(negedge clk) disable iff (!arst_n)
		(!rd_req && !wr_req) |-> (!rw_wait && !bus_req && !bus_rd && !bus_wr))
		else begin
			errors++;
			$display("mismatch at %0t: bus or wait active while idle", $time);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		!(bus_rd && bus_wr) && ((bus_rd || bus_wr) -> bus_ack))
		else begin
			errors++;
			$display("mismatch at %0t: bad bus strobes", $time);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		(rd_req && exp_hit) |-> (!rw_wait && !bus_rd && !bus_req))
		else begin
			errors++;
			$display("mismatch at %0t: read hit %h waited", $time, addr);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		(rd_req && !exp_hit) |-> (rw_wait && bus_req && !bus_wr))
		else begin
			errors++;
			$display("mismatch at %0t: read miss %h not held", $time, addr);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		(rd_req && !rw_wait) |-> (rd_data == exp_rd_data))
		else begin
			errors++;
			$display("mismatch at %0t: rd_data %h, expected %h", $time, rd_data, exp_rd_data);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		(bus_rd && bus_ready) |-> (bus_addr == exp_fill_addr))
		else begin
			errors++;
			$display("mismatch at %0t: fill beat at %h, expected %h", $time, bus_addr,
				exp_fill_addr);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		exp_abandon |-> !bus_rd)
		else begin
			errors++;
			$display("mismatch at %0t: fill beat on a dropped line", $time);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		bus_wr |-> ((bus_addr == addr) && (bus_wdata == wr_data)))
		else begin
			errors++;
			$display("mismatch at %0t: write beat %h", $time, bus_addr);
		end

	assert property (@(negedge clk) disable iff (!arst_n)
		(wr_req && !rd_req) |-> (bus_req && (rw_wait == !(bus_ack && bus_ready))))
		else begin
			errors++;
			$display("mismatch at %0t: write request or wait wrong", $time);
		end

	// All tasks start and end 1 ns after a rising edge
	task automatic start_read(input logic [31:0] a);
		addr           = a;
		wr_req         = 1'b0;
		rd_req         = 1'b1;
		beats_at_start = rd_beats;
	endtask

	task automatic wait_beats(input int n);
		int waited;
		waited = 0;
		while (((rd_beats - beats_at_start) < n) && (waited < TIMEOUT)) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if ((rd_beats - beats_at_start) < n) begin
			timeouts++;
			$display("timeout: fill beats for %h did not arrive", addr);
		end
	endtask

	task automatic finish_read(input int exp_beats);
		int waited;
		waited = 0;
		@(negedge clk);
		while (rw_wait && (waited < TIMEOUT)) begin
			@(negedge clk);
			waited++;
		end
		if (rw_wait) begin
			timeouts++;
			$display("timeout: read of %h never completed", addr);
		end
		@(posedge clk);
		#1;
		rd_req = 1'b0;
		assert (rd_beats - beats_at_start == exp_beats)
		else begin
			errors++;
			$display("mismatch at %0t: %0d fill beats for %h, expected %0d", $time,
				rd_beats - beats_at_start, addr, exp_beats);
		end
	endtask

	task automatic read_word(input logic [31:0] a, input int exp_beats);
		start_read(a);
		finish_read(exp_beats);
	endtask

	task automatic write_word(input logic [31:0] a, input logic [31:0] d);
		int waited;
		int start;
		start   = wr_beats;
		waited  = 0;
		addr    = a;
		wr_data = d;
		rd_req  = 1'b0;
		wr_req  = 1'b1;
		@(negedge clk);
		while (rw_wait && (waited < TIMEOUT)) begin
			@(negedge clk);
			waited++;
		end
		if (rw_wait) begin
			timeouts++;
			$display("timeout: write to %h never completed", a);
		end
		@(posedge clk);
		#1;
		wr_req = 1'b0;
		assert (wr_beats - start == 1)
		else begin
			errors++;
			$display("mismatch at %0t: %0d write beats for %h", $time, wr_beats - start, a);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	initial begin
		int          i;
		logic [31:0] a;
		clk       = 1'b0;
		arst_n    = 1'b0;
		addr      = '0;
		rd_req    = 1'b0;
		wr_req    = 1'b0;
		wr_data   = '0;
		bus_ack   = 1'b0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		void'($urandom(32'h2d294cb0));
		idle(8);
		arst_n = 1'b1;
		idle(3);

		read_word(32'h0000_1040, 16);        // Cold miss
		read_word(32'h0000_1044, 0);
		read_word(32'h0000_107c, 0);
		write_word(32'h0000_1048, 32'hdead_beef);  // Write hit
		read_word(32'h0000_1048, 0);
		idle(2);

		write_word(32'h0000_2080, 32'h1234_5678);  // Write miss does not allocate
		read_word(32'h0000_2080, 16);

		read_word(32'h0000_3040, 16);        // Same index with another tag
		read_word(32'h0000_1040, 16);
		read_word(32'h0000_1048, 0);

		start_read(32'h0000_4100);           // Switch lines part-way
		wait_beats(5);
		start_read(32'h0000_5140);
		finish_read(16);
		read_word(32'h0000_4100, 16);

		start_read(32'h0000_6180);           // Switch to a resident line
		wait_beats(3);
		start_read(32'h0000_1040);
		finish_read(0);
		read_word(32'h0000_7180, 16);
		idle(2);

		for (i = 0; i < 48; i++) begin
			a = (($urandom % 3) << 10) | (($urandom % 4) << 6) | (($urandom % 16) << 2);
			if (($urandom % 3) == 0)
				write_word(a, $urandom);
			else
				read_word(a, resident(a) ? 0 : 16);
			if (($urandom % 8) == 0)
				idle(1);
		end
		idle(4);

		$display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: vlog.f
dcache_pkg.sv
dcache_fill_if.sv
dcache_bus_if.sv
dcache_lookup.sv
dcache_miss.sv
dcache_top.sv
tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and
# judges the result from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_dcache -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
